/* sources.f */
common/mem_pkg.sv
axi_sram/sram_array.sv
axi_sram/axi_sram.sv
source/req_bridge.sv
source/rsp_fifo.sv
source/mem_subsystem.sv
dv/mem_subsystem_tb.sv

/* dv/mem_subsystem_tb.sv */
`default_nettype none

module mem_subsystem_tb;

	// upper 21 address bits of the sram window
	localparam logic [20:0] WIN_TAG = 21'h10_0000;
	localparam int WAIT_LIMIT = 50;
	localparam int RANDOM_TXNS = 400;

	logic           clk;
	logic           rst;
	logic           req_valid;
	logic           req_write;
	mem_pkg::addr_t req_addr;
	mem_pkg::data_t req_wdata;
	mem_pkg::strb_t req_wstrb;
	logic           req_ready;
	logic           rsp_valid;
	logic           rsp_write;
	mem_pkg::resp_t rsp_resp;
	mem_pkg::data_t rsp_rdata;
	logic           rsp_ready;

	integer seed;
	// reference memory plus the bytes written so far
	mem_pkg::data_t model_mem [256];
	mem_pkg::strb_t model_known [256];
	// expected responses with the oldest at the front
	logic           exp_write [$];
	mem_pkg::resp_t exp_resp [$];
	mem_pkg::data_t exp_data [$];
	mem_pkg::data_t exp_mask [$];
	int             accepted;
	int             popped;
	// request taken at the last edge
	logic           taken;

	mem_subsystem u_mem_subsystem (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_wstrb (req_wstrb),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_write (rsp_write),
		.rsp_resp  (rsp_resp),
		.rsp_rdata (rsp_rdata),
		.rsp_ready (rsp_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_data(input string name, input mem_pkg::data_t got,
			input mem_pkg::data_t want);
		if (got !== want) begin
			$display("Error: %s is %h, expected %h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_resp(input string name, input mem_pkg::resp_t got,
			input mem_pkg::resp_t want);
		if (got !== want) begin
			$display("Error: %s is %h, expected %h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_kind(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("Error: %s is %h, expected %h", name, got, want);
			abort_run();
		end
	endtask

	// handshake and status flags
	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("Error: %s is %h, expected %h", name, got, want);
			abort_run();
		end
	endtask

	// one strobe bit widened to a byte lane
	function automatic mem_pkg::data_t byte_mask(mem_pkg::strb_t s);
		mem_pkg::data_t m;
		for (int b = 0; b < 8; b++) begin
			m[8*b +: 8] = {8{s[b]}};
		end
		return m;
	endfunction

	// accepted request applied to the model in order
	task automatic apply_request();
		logic hit;
		int   idx;
		hit = (req_addr[31:11] == WIN_TAG);
		idx = req_addr[10:3];
		exp_write.push_back(req_write);
		exp_resp.push_back(hit ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR);
		if (req_write) begin
			// write responses carry zero data
			exp_data.push_back('0);
			exp_mask.push_back('1);
			if (hit) begin
				for (int b = 0; b < 8; b++) begin
					if (req_wstrb[b]) begin
						model_mem[idx][8*b +: 8] = req_wdata[8*b +: 8];
					end
				end
				model_known[idx] = model_known[idx] | req_wstrb;
			end
		end else if (hit) begin
			exp_data.push_back(model_mem[idx]);
			// unwritten bytes are unknown and left out of the compare
			exp_mask.push_back(byte_mask(model_known[idx]));
		end else begin
			exp_data.push_back('0);
			exp_mask.push_back('1);
		end
		accepted++;
		taken = 1'b1;
	endtask

	task automatic match_response();
		mem_pkg::data_t mask;
		if (exp_write.size() == 0) begin
			$display("a response was popped with no request outstanding");
			abort_run();
		end
		mask = exp_mask.pop_front();
		check_kind("rsp_write", rsp_write, exp_write.pop_front());
		check_resp("rsp_resp", rsp_resp, exp_resp.pop_front());
		check_data("rsp_rdata", rsp_rdata & mask, exp_data.pop_front() & mask);
		popped++;
	endtask

	// outputs are settled at the falling edge
	// handshakes seen here complete at the next rising edge
	task automatic tick();
		taken = 1'b0;
		if (req_valid && req_ready) begin
			apply_request();
		end
		if (rsp_valid && rsp_ready) begin
			match_response();
		end
		@(negedge clk);
	endtask

	task automatic send_one(input logic write, input mem_pkg::addr_t addr,
			input mem_pkg::data_t data, input mem_pkg::strb_t strb);
		int waited;
		req_valid = 1'b1;
		req_write = write;
		req_addr  = addr;
		req_wdata = data;
		req_wstrb = strb;
		waited = 0;
		while (!req_ready) begin
			tick();
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("timed out waiting for req_ready on a directed request");
				abort_run();
			end
		end
		tick();
		req_valid = 1'b0;
	endtask

	task automatic recv_one();
		int waited;
		rsp_ready = 1'b1;
		waited = 0;
		while (!rsp_valid) begin
			tick();
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("timed out waiting for rsp_valid on a directed response");
				abort_run();
			end
		end
		tick();
		rsp_ready = 1'b0;
	endtask

	// called right after the handshake with the fifo empty
	task automatic expect_latency(input int cycles);
		int waited;
		waited = 1;
		while (!rsp_valid) begin
			tick();
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("timed out waiting for rsp_valid in the latency check");
				abort_run();
			end
		end
		if (waited != cycles) begin
			$display("response latency was %0d cycles, expected %0d", waited, cycles);
			abort_run();
		end
	endtask

	// mostly low word indices so reads hit written data
	task automatic random_request();
		logic [31:0] r;
		logic [31:0] r2;
		logic [7:0]  idx;
		int          pos;
		r   = $random(seed);
		r2  = $random(seed);
		idx = r[8] ? r[16:9] : {3'b000, r[13:9]};
		req_write = r[0];
		req_addr  = mem_pkg::MEM_BASE | {21'd0, idx, r[19:17]};
		if (r[23:20] == 4'd0) begin
			// one flipped tag bit leaves the window
			pos = 11 + (r[28:24] % 21);
			req_addr[pos] = ~req_addr[pos];
		end
		req_wdata = {$random(seed), $random(seed)};
		req_wstrb = r[29] ? 8'hff : r2[7:0];
	endtask

	initial begin
		logic [31:0] r;
		int          start;
		int          sent;
		int          waited;
		seed      = 32'h99a7;
		rst       = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		req_wstrb = '0;
		rsp_ready = 1'b0;
		accepted  = 0;
		popped    = 0;
		taken     = 1'b0;
		for (int i = 0; i < 256; i++) begin
			model_mem[i]   = '0;
			model_known[i] = '0;
		end
		repeat (4) @(negedge clk);
		rst = 1'b0;

		// idle after reset
		check_flag("rsp_valid", rsp_valid, 1'b0);
		check_flag("req_ready", req_ready, 1'b1);

		// full write and partial write, then read back the merge
		send_one(1'b1, 32'h8000_0040, 64'h0123_4567_89ab_cdef, 8'hff);
		expect_latency(3);
		recv_one();
		send_one(1'b1, 32'h8000_0045, 64'hfedc_ba98_7654_3210, 8'h5a);
		recv_one();
		send_one(1'b0, 32'h8000_0043, '0, '0);
		expect_latency(3);
		recv_one();

		// out-of-window accesses aliasing the same word index
		send_one(1'b0, 32'h0000_0040, '0, '0);
		recv_one();
		send_one(1'b1, 32'h0000_0040, 64'hdead_beef_dead_beef, 8'hff);
		recv_one();
		send_one(1'b0, 32'h8000_0040, '0, '0);
		recv_one();

		// credits run out at four under back-pressure
		rsp_ready = 1'b0;
		start = accepted;
		random_request();
		req_valid = 1'b1;
		for (int c = 0; c < 20; c++) begin
			tick();
			if (taken) begin
				random_request();
			end
			if (accepted - start == 4) begin
				check_flag("req_ready", req_ready, 1'b0);
			end
		end
		req_valid = 1'b0;
		if (accepted - start != 4) begin
			$display("%0d requests accepted with rsp_ready low, expected 4", accepted - start);
			abort_run();
		end
		recv_one();
		// one pop returns one credit
		check_flag("req_ready", req_ready, 1'b1);
		repeat (3) recv_one();

		// random traffic on both ports
		sent = 0;
		waited = 0;
		while (sent < RANDOM_TXNS || popped < accepted) begin
			r = $random(seed);
			rsp_ready = (r[1:0] != 2'b00);
			if (!req_valid && sent < RANDOM_TXNS && r[2]) begin
				random_request();
				req_valid = 1'b1;
			end
			tick();
			if (taken) begin
				req_valid = 1'b0;
				sent++;
			end
			waited++;
			if (waited > RANDOM_TXNS * 40) begin
				$display("timed out in random traffic, %0d sent, %0d popped", sent, popped);
				abort_run();
			end
		end
		rsp_ready = 1'b0;

		// every expected response is out, so the queue must stay empty
		repeat (4) tick();
		if (!rsp_valid) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("an extra response appeared after the last expected one");
			abort_run();
		end
	end

endmodule

`default_nettype wire

/* source/mem_subsystem.sv */
`default_nettype none

module mem_subsystem (
	input  logic            clk,
	input  logic            rst,
	input  logic            req_valid,
	input  logic            req_write,
	input  mem_pkg::addr_t  req_addr,
	input  mem_pkg::data_t  req_wdata,
	input  mem_pkg::strb_t  req_wstrb,
	output logic            req_ready,
	output logic            rsp_valid,
	output logic            rsp_write,
	output mem_pkg::resp_t  rsp_resp,
	output mem_pkg::data_t  rsp_rdata,
	input  logic            rsp_ready
);

	// bridge to slave
	logic           arvalid;
	mem_pkg::addr_t araddr;
	logic           arready;
	logic           awvalid;
	mem_pkg::addr_t awaddr;
	logic           awready;
	logic           wvalid;
	mem_pkg::data_t wdata;
	mem_pkg::strb_t wstrb;
	logic           wready;

	// slave to fifo
	logic           rvalid;
	mem_pkg::data_t rdata;
	mem_pkg::resp_t rresp;
	logic           rready;
	logic           bvalid;
	mem_pkg::resp_t bresp;
	logic           bready;

	// credit return
	logic           rsp_pop;

	req_bridge u_req_bridge (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_wstrb (req_wstrb),
		.req_ready (req_ready),
		.arvalid   (arvalid),
		.araddr    (araddr),
		.arready   (arready),
		.awvalid   (awvalid),
		.awaddr    (awaddr),
		.awready   (awready),
		.wvalid    (wvalid),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wready    (wready),
		.rsp_pop   (rsp_pop)
	);

	axi_sram u_axi_sram (
		.clk     (clk),
		.rst     (rst),
		.arvalid (arvalid),
		.araddr  (araddr),
		.arready (arready),
		.awvalid (awvalid),
		.awaddr  (awaddr),
		.awready (awready),
		.wvalid  (wvalid),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wready  (wready),
		.rvalid  (rvalid),
		.rdata   (rdata),
		.rresp   (rresp),
		.rready  (rready),
		.bvalid  (bvalid),
		.bresp   (bresp),
		.bready  (bready)
	);

	rsp_fifo u_rsp_fifo (
		.clk       (clk),
		.rst       (rst),
		.rvalid    (rvalid),
		.rdata     (rdata),
		.rresp     (rresp),
		.rready    (rready),
		.bvalid    (bvalid),
		.bresp     (bresp),
		.bready    (bready),
		.rsp_valid (rsp_valid),
		.rsp_write (rsp_write),
		.rsp_resp  (rsp_resp),
		.rsp_rdata (rsp_rdata),
		.rsp_ready (rsp_ready),
		.rsp_pop   (rsp_pop)
	);

endmodule

`default_nettype wire

/* source/rsp_fifo.sv */
`default_nettype none

module rsp_fifo (
	input  logic            clk,
	input  logic            rst,
	input  logic            rvalid,
	input  mem_pkg::data_t  rdata,
	input  mem_pkg::resp_t  rresp,
	output logic            rready,
	input  logic            bvalid,
	input  mem_pkg::resp_t  bresp,
	output logic            bready,
	output logic            rsp_valid,
	output logic            rsp_write,
	output mem_pkg::resp_t  rsp_resp,
	output mem_pkg::data_t  rsp_rdata,
	input  logic            rsp_ready,
	output logic            rsp_pop
);

	logic [mem_pkg::RSP_PTR_W-1:0] wr_ptr;
	logic [mem_pkg::RSP_PTR_W-1:0] rd_ptr;
	// occupancy, 0 to RSP_DEPTH
	mem_pkg::credit_t              count;
	logic                          full;
	logic                          push_r;
	logic                          push_b;
	logic                          push;

	// entry slots
	logic           ent_write [mem_pkg::RSP_DEPTH];
	mem_pkg::resp_t ent_resp  [mem_pkg::RSP_DEPTH];
	mem_pkg::data_t ent_data  [mem_pkg::RSP_DEPTH];

	assign full   = (count == mem_pkg::RSP_DEPTH);
	assign rready = !full;
	assign bready = !full;

	assign push_r = rvalid && rready;
	assign push_b = bvalid && bready;
	assign push   = push_r || push_b;

	// head entry
	assign rsp_valid = (count != '0);
	assign rsp_write = ent_write[rd_ptr];
	assign rsp_resp  = ent_resp[rd_ptr];
	assign rsp_rdata = ent_data[rd_ptr];
	assign rsp_pop   = rsp_valid && rsp_ready;

	// r and b merged into one entry format, write data zeroed
	always_ff @(posedge clk) begin
		if (push) begin
			ent_write[wr_ptr] <= push_b;
			ent_resp[wr_ptr]  <= push_b ? bresp : rresp;
			ent_data[wr_ptr]  <= push_b ? '0 : rdata;
		end
	end

	// pointers wrap on their own at depth 4
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rsp_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !rsp_pop) begin
				count <= count + 1'b1;
			end else if (rsp_pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// bridge credits keep the slave from offering a beat to a full queue
	a_no_beat_full: assert property (@(posedge clk) disable iff (rst)
		!((rvalid || bvalid) && full));

endmodule

`default_nettype wire

/* source/req_bridge.sv */
`default_nettype none

module req_bridge (
	input  logic            clk,
	input  logic            rst,
	input  logic            req_valid,
	input  logic            req_write,
	input  mem_pkg::addr_t  req_addr,
	input  mem_pkg::data_t  req_wdata,
	input  mem_pkg::strb_t  req_wstrb,
	output logic            req_ready,
	output logic            arvalid,
	output mem_pkg::addr_t  araddr,
	input  logic            arready,
	output logic            awvalid,
	output mem_pkg::addr_t  awaddr,
	input  logic            awready,
	output logic            wvalid,
	output mem_pkg::data_t  wdata,
	output mem_pkg::strb_t  wstrb,
	input  logic            wready,
	input  logic            rsp_pop
);

	// transactions taken but not yet popped by the client
	mem_pkg::credit_t credit;
	// one address register serves both channels
	mem_pkg::addr_t   addr_q;
	logic             chan_busy;
	logic             accept;

	// any channel still waiting on the slave
	assign chan_busy = arvalid || awvalid || wvalid;
	assign req_ready = !chan_busy && (credit < mem_pkg::RSP_DEPTH);
	assign accept    = req_valid && req_ready;

	assign araddr = addr_q;
	assign awaddr = addr_q;

	// channel valids, set on accept, dropped on handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end else if (accept) begin
			arvalid <= !req_write;
			// aw and w go up together
			awvalid <= req_write;
			wvalid  <= req_write;
		end else begin
			if (arvalid && arready) begin
				arvalid <= 1'b0;
			end
			if (awvalid && awready) begin
				awvalid <= 1'b0;
			end
			if (wvalid && wready) begin
				wvalid <= 1'b0;
			end
		end
	end

	// payload held stable while a valid is up
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= req_addr;
			wdata  <= req_wdata;
			wstrb  <= req_wstrb;
		end
	end

	// credit count, up on accept, down on each client pop
	always_ff @(posedge clk) begin
		if (rst) begin
			credit <= '0;
		end else if (accept && !rsp_pop) begin
			credit <= credit + 1'b1;
		end else if (rsp_pop && !accept) begin
			credit <= credit - 1'b1;
		end
	end

	// the fifo never holds more beats than were granted
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credit <= mem_pkg::RSP_DEPTH);

	// a pop always has a matching outstanding request
	a_credit_min: assert property (@(posedge clk) disable iff (rst)
		!(rsp_pop && credit == '0));

endmodule

`default_nettype wire

/* axi_sram/axi_sram.sv */
`default_nettype none

module axi_sram (
	input  logic            clk,
	input  logic            rst,
	input  logic            arvalid,
	input  mem_pkg::addr_t  araddr,
	output logic            arready,
	input  logic            awvalid,
	input  mem_pkg::addr_t  awaddr,
	output logic            awready,
	input  logic            wvalid,
	input  mem_pkg::data_t  wdata,
	input  mem_pkg::strb_t  wstrb,
	output logic            wready,
	output logic            rvalid,
	output mem_pkg::data_t  rdata,
	output mem_pkg::resp_t  rresp,
	input  logic            rready,
	output logic            bvalid,
	output mem_pkg::resp_t  bresp,
	input  logic            bready
);

	mem_pkg::sram_state_t state;
	// response code of the access in flight
	mem_pkg::resp_t       resp_q;
	// read hit the window and returns array data
	logic                 rd_ok;
	logic                 rd_acc;
	logic                 wr_acc;
	logic                 ar_hit;
	logic                 aw_hit;
	mem_pkg::word_idx_t   rd_idx;
	mem_pkg::word_idx_t   wr_idx;
	mem_pkg::data_t       rd_data;

	// ready in idle only
	assign arready = (state == mem_pkg::idle);
	// write needs both aw and w
	// read wins a tie
	assign awready = (state == mem_pkg::idle) && awvalid && wvalid && !arvalid;
	assign wready  = awready;

	assign rd_acc = arvalid && arready;
	assign wr_acc = awvalid && awready;

	// window decode
	assign ar_hit = mem_pkg::in_window(araddr);
	assign aw_hit = mem_pkg::in_window(awaddr);
	assign rd_idx = mem_pkg::word_idx(araddr);
	assign wr_idx = mem_pkg::word_idx(awaddr);

	// array only touched for in-window addresses
	sram_array u_sram_array (
		.clk     (clk),
		.rd_en   (rd_acc && ar_hit),
		.rd_idx  (rd_idx),
		.rd_data (rd_data),
		.wr_en   (wr_acc && aw_hit),
		.wr_idx  (wr_idx),
		.wr_data (wdata),
		.wr_strb (wstrb)
	);

	// one access at a time until its beat is taken
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_pkg::idle;
		end else begin
			case (state)
				mem_pkg::idle: begin
					if (rd_acc) begin
						state <= mem_pkg::read_rsp;
					end else if (wr_acc) begin
						state <= mem_pkg::write_rsp;
					end
				end
				mem_pkg::read_rsp: begin
					if (rready) begin
						state <= mem_pkg::idle;
					end
				end
				mem_pkg::write_rsp: begin
					if (bready) begin
						state <= mem_pkg::idle;
					end
				end
				default: begin
					state <= mem_pkg::idle;
				end
			endcase
		end
	end

	// capture hit and response code at accept
	always_ff @(posedge clk) begin
		if (rd_acc) begin
			rd_ok  <= ar_hit;
			resp_q <= ar_hit ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
		end else if (wr_acc) begin
			resp_q <= aw_hit ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
		end
	end

	// beats come straight from the state
	assign rvalid = (state == mem_pkg::read_rsp);
	assign bvalid = (state == mem_pkg::write_rsp);
	assign rresp  = resp_q;
	assign bresp  = resp_q;
	// array output holds until the next read
	assign rdata  = rd_ok ? rd_data : '0;

	// bridge issues one channel at a time
	a_ar_aw_excl: assert property (@(posedge clk) disable iff (rst)
		!(arvalid && awvalid));

endmodule

`default_nettype wire

/* axi_sram/sram_array.sv */
`default_nettype none

module sram_array (
	input  logic                clk,
	input  logic                rd_en,
	input  mem_pkg::word_idx_t  rd_idx,
	output mem_pkg::data_t      rd_data,
	input  logic                wr_en,
	input  mem_pkg::word_idx_t  wr_idx,
	input  mem_pkg::data_t      wr_data,
	input  mem_pkg::strb_t      wr_strb
);

	// storage, contents undefined until written
	mem_pkg::data_t mem [mem_pkg::MEM_WORDS];

	// byte lanes written only where strobed
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < $bits(mem_pkg::strb_t); b++) begin
				if (wr_strb[b]) begin
					mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

	// registered read, data one cycle after rd_en
	// and held until the next read
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_idx];
		end
	end

endmodule

`default_nettype wire

/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	// byte address and one data word
	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;
	// one strobe bit per data byte
	typedef logic [7:0] strb_t;
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'd0;
	// address outside the sram window
	localparam resp_t RESP_SLVERR = 2'd2;

	localparam addr_t MEM_BASE = 32'h8000_0000;
	localparam int MEM_WORDS = 256;
	// window compare covers the bits above the array span
	localparam int WIN_LSB = 11;
	typedef logic [7:0] word_idx_t;

	// fifo slots, also the credit limit
	localparam int RSP_DEPTH = 4;
	localparam int RSP_PTR_W = 2;
	typedef logic [2:0] credit_t;

	typedef enum logic [1:0] {
		idle,
		read_rsp,
		write_rsp
	} sram_state_t;

	// upper 21 bits must match the base
	function automatic logic in_window(addr_t addr);
		return addr[31:WIN_LSB] == MEM_BASE[31:WIN_LSB];
	endfunction

	// word index, byte offset dropped
	function automatic word_idx_t word_idx(addr_t addr);
		return addr[10:3];
	endfunction

endpackage

`default_nettype wire
